/* vlog.f */
aluPkg.sv
aluControl.sv
adderSubtractor.sv
logicUnit.sv
resultStage.sv
aluTop.sv
aluTb.sv

/* Makefile */
# Verilator build and run for the ALU testbench

VERILATOR ?= verilator
TOP       ?= aluTb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* aluTb.sv */
// Self-checking testbench for the registered ALU with a directed table and random vectors
`timescale 1ns/1ps

module aluTb;

    import aluPkg::*;

    typedef logic [defaultDataWidth-1:0] word_t;

    // One directed case with its expected outputs
    typedef struct packed {
        aluCmd_t cmd;
        word_t   a;
        word_t   b;
        word_t   res;
        logic    carry;
        logic    zero;
        logic    ovf;
    } aluCase_t;

    localparam int msb         = defaultDataWidth - 1;
    localparam int resetCycles = 3;
    localparam int numCases    = 25;
    localparam int numRandom   = 40;
    localparam int cycleLimit  = resetCycles + numCases + numRandom + 20;

    logic    clk = 1'b0;
    logic    arstN;
    aluCmd_t command;
    word_t   operandA;
    word_t   operandB;
    word_t   result;
    logic    carryOut;
    logic    zero;
    logic    overflow;

    aluCase_t cases [numCases];
    int       caseCount  = 0;
    int       testCount  = 0;
    int       failCount  = 0;
    int       errorCount = 0;
    int       cycleCount = 0;
    int       seed;

    aluTop #(
        .dataWidth (defaultDataWidth)
    ) DUT (
        .clk      (clk),
        .arstN    (arstN),
        .command  (command),
        .operandA (operandA),
        .operandB (operandB),
        .result   (result),
        .carryOut (carryOut),
        .zero     (zero),
        .overflow (overflow)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic string cmdName(input aluCmd_t cmd);
        case (cmd)
            cmdAdd:  return "ADD";
            cmdSub:  return "SUB";
            cmdXor:  return "XOR";
            cmdSlt:  return "SLT";
            cmdAnd:  return "AND";
            cmdNand: return "NAND";
            cmdNor:  return "NOR";
            default: return "OR";
        endcase
    endfunction

    task automatic compareWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAIL %0t ns %s expected %h actual %h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic compareFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %0t ns %s expected %b actual %b", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic addCase(input aluCmd_t cmd, input word_t a, input word_t b, input word_t res,
                           input logic carry, input logic zeroFlag, input logic ovf);
        if (caseCount < numCases) begin
            cases[caseCount] = '{cmd, a, b, res, carry, zeroFlag, ovf};
        end
        caseCount++;
    endtask

    // Hand-picked cases, columns are command, A, B, result, carry, zero, overflow
    task automatic fillTable();
        addCase(cmdAdd,  32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
        addCase(cmdAdd,  32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 1'b1, 1'b1, 1'b0);
        addCase(cmdAdd,  32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000, 1'b0, 1'b0, 1'b1);
        addCase(cmdAdd,  32'h8000_0000, 32'h8000_0000, 32'h0000_0000, 1'b1, 1'b1, 1'b1);
        addCase(cmdAdd,  32'h0000_0005, 32'h0000_0007, 32'h0000_000C, 1'b0, 1'b0, 1'b0);
        addCase(cmdSub,  32'h0000_0005, 32'h0000_0005, 32'h0000_0000, 1'b1, 1'b1, 1'b0);
        addCase(cmdSub,  32'h0000_0003, 32'h0000_0005, 32'hFFFF_FFFE, 1'b0, 1'b0, 1'b0);
        addCase(cmdSub,  32'h8000_0000, 32'h0000_0001, 32'h7FFF_FFFF, 1'b1, 1'b0, 1'b1);
        addCase(cmdSub,  32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'h8000_0000, 1'b0, 1'b0, 1'b1);
        addCase(cmdSlt,  32'h0000_0003, 32'h0000_0005, 32'h0000_0001, 1'b0, 1'b0, 1'b0);
        addCase(cmdSlt,  32'h0000_0005, 32'h0000_0003, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
        // Subtraction overflows in the next two
        addCase(cmdSlt,  32'h8000_0000, 32'h0000_0001, 32'h0000_0001, 1'b0, 1'b0, 1'b0);
        addCase(cmdSlt,  32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
        addCase(cmdSlt,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
        addCase(cmdSlt,  32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0001, 1'b0, 1'b0, 1'b0);
        addCase(cmdXor,  32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0FF0_0FF0, 1'b0, 1'b0, 1'b0);
        addCase(cmdXor,  32'h1234_5678, 32'h1234_5678, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
        addCase(cmdAnd,  32'hF0F0_F0F0, 32'hFF00_FF00, 32'hF000_F000, 1'b0, 1'b0, 1'b0);
        addCase(cmdNand, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0FFF_0FFF, 1'b0, 1'b0, 1'b0);
        addCase(cmdNor,  32'hF0F0_F0F0, 32'hFF00_FF00, 32'h000F_000F, 1'b0, 1'b0, 1'b0);
        addCase(cmdOr,   32'hF0F0_F0F0, 32'hFF00_FF00, 32'hFFF0_FFF0, 1'b0, 1'b0, 1'b0);
        addCase(cmdAnd,  32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
        addCase(cmdNor,  32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
        addCase(cmdOr,   32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
        addCase(cmdNand, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
    endtask

    // Expected ALU behaviour from the signed and unsigned arithmetic rules
    task automatic modelAlu(input aluCmd_t cmd, input word_t a, input word_t b,
                            output word_t res, output logic carry, output logic ovf);
        logic [defaultDataWidth:0] wide;
        res   = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (cmd)
            cmdAdd: begin
                wide  = {1'b0, a} + {1'b0, b};
                res   = wide[msb:0];
                carry = wide[defaultDataWidth];
                // Same-sign operands giving a result of the other sign
                ovf   = (a[msb] == b[msb]) && (res[msb] != a[msb]);
            end
            cmdSub: begin
                wide  = {1'b0, a} + {1'b0, ~b} + (defaultDataWidth + 1)'(1);
                res   = wide[msb:0];
                carry = wide[defaultDataWidth];
                ovf   = (a[msb] != b[msb]) && (res[msb] != a[msb]);
            end
            cmdSlt:  res = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
            cmdXor:  res = a ^ b;
            cmdAnd:  res = a & b;
            cmdNand: res = ~(a & b);
            cmdNor:  res = ~(a | b);
            default: res = a | b;
        endcase
    endtask

    // Applies one vector at a falling edge and checks it one cycle later
    task automatic runCase(input string label, input aluCmd_t cmd, input word_t a,
                           input word_t b, input word_t expRes, input logic expCarry,
                           input logic expZero, input logic expOvf);
        int errorsBefore;
        errorsBefore = errorCount;
        command  = cmd;
        operandA = a;
        operandB = b;
        @(negedge clk);
        compareWord("result", expRes, result);
        compareFlag("carryOut", expCarry, carryOut);
        compareFlag("zero", expZero, zero);
        compareFlag("overflow", expOvf, overflow);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %0d %s %h %h: ok", testCount, label, a, b);
        end else begin
            failCount++;
            $display("test %0d %s %h %h: mismatch", testCount, label, a, b);
        end
    endtask

    task automatic checkReset(input string label);
        int errorsBefore;
        errorsBefore = errorCount;
        compareWord("result", '0, result);
        compareFlag("carryOut", 1'b0, carryOut);
        compareFlag("zero", 1'b1, zero);
        compareFlag("overflow", 1'b0, overflow);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %0d %s: ok", testCount, label);
        end else begin
            failCount++;
            $display("test %0d %s: outputs not cleared", testCount, label);
        end
    endtask

    initial begin
        aluCase_t    c;
        logic [31:0] randBits;
        aluCmd_t     randCmd;
        word_t       randA;
        word_t       randB;
        word_t       expRes;
        logic        expCarry;
        logic        expOvf;
        seed     = 32'hd7d26cca;
        arstN    = 1'b0;
        // Operands that carry and overflow, so only the reset keeps the outputs clear
        command  = cmdAdd;
        operandA = 32'hFFFF_FFFF;
        operandB = 32'h8000_0000;
        fillTable();
        if (caseCount != numCases) begin
            $display("Stimulus table holds %0d cases but %0d were expected",
                     caseCount, numCases);
            errorCount++;
        end

        repeat (resetCycles) @(negedge clk);
        arstN = 1'b1;
        // Still before the first capture
        checkReset("state after reset");

        for (int i = 0; i < numCases; i++) begin
            c = cases[i];
            runCase($sformatf("table %s", cmdName(c.cmd)), c.cmd, c.a, c.b,
                    c.res, c.carry, c.zero, c.ovf);
        end

        for (int i = 0; i < numRandom; i++) begin
            randBits = $random(seed);
            randCmd  = randBits[2:0];
            randA    = $random(seed);
            randB    = $random(seed);
            modelAlu(randCmd, randA, randB, expRes, expCarry, expOvf);
            runCase($sformatf("random %s", cmdName(randCmd)), randCmd, randA, randB,
                    expRes, expCarry, (expRes == '0), expOvf);
        end

        // Load nonzero outputs, then reset away from any rising edge
        runCase("preload ADD", cmdAdd, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF,
                1'b1, 1'b0, 1'b1);
        arstN = 1'b0;
        #1;
        checkReset("asynchronous reset");
        @(negedge clk);
        arstN = 1'b1;

        $display("%0d tests run, %0d passed, %0d failed",
                 testCount, testCount - failCount, failCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* aluTop.sv */
// Registered 32-bit ALU top level joining the decoder, datapath units and result stage
`timescale 1ns/1ps

module aluTop #(
    parameter int dataWidth = aluPkg::defaultDataWidth
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  aluPkg::aluCmd_t      command,
    input  logic [dataWidth-1:0] operandA,
    input  logic [dataWidth-1:0] operandB,
    output logic [dataWidth-1:0] result,
    output logic                 carryOut,
    output logic                 zero,
    output logic                 overflow
);

    import aluPkg::*;

    resultSel_t           resultSel;
    logic                 invertB;
    logic                 invertOut;
    logic                 carryIn;

    logic [dataWidth-1:0] sum;
    logic                 arithCarry;
    logic                 arithOverflow;
    logic [dataWidth-1:0] xorResult;
    logic [dataWidth-1:0] nandResult;
    logic [dataWidth-1:0] norResult;

    aluControl uControl (
        .command   (command),
        .resultSel (resultSel),
        .invertB   (invertB),
        .invertOut (invertOut),
        .carryIn   (carryIn)
    );

    adderSubtractor #(
        .dataWidth (dataWidth)
    ) uAdder (
        .a        (operandA),
        .b        (operandB),
        .invertB  (invertB),
        .carryIn  (carryIn),
        .sum      (sum),
        .carryOut (arithCarry),
        .overflow (arithOverflow)
    );

    logicUnit #(
        .dataWidth (dataWidth)
    ) uLogic (
        .a          (operandA),
        .b          (operandB),
        .invertOut  (invertOut),
        .xorResult  (xorResult),
        .nandResult (nandResult),
        .norResult  (norResult)
    );

    // Single register stage, so outputs follow inputs by one cycle
    resultStage #(
        .dataWidth (dataWidth)
    ) uResult (
        .clk           (clk),
        .arstN         (arstN),
        .resultSel     (resultSel),
        .sum           (sum),
        .arithCarry    (arithCarry),
        .arithOverflow (arithOverflow),
        .xorResult     (xorResult),
        .nandResult    (nandResult),
        .norResult     (norResult),
        .result        (result),
        .carryOut      (carryOut),
        .zero          (zero),
        .overflow      (overflow)
    );

endmodule

/* resultStage.sv */
// Result selection, SLT forming, flag gating and the registered ALU outputs
`timescale 1ns/1ps

module resultStage #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  aluPkg::resultSel_t   resultSel,
    input  logic [dataWidth-1:0] sum,
    input  logic                 arithCarry,
    input  logic                 arithOverflow,
    input  logic [dataWidth-1:0] xorResult,
    input  logic [dataWidth-1:0] nandResult,
    input  logic [dataWidth-1:0] norResult,
    output logic [dataWidth-1:0] result,
    output logic                 carryOut,
    output logic                 zero,
    output logic                 overflow
);

    import aluPkg::*;

    logic [dataWidth-1:0] sltWord;
    logic [dataWidth-1:0] nextResult;
    logic                 isArith;
    logic                 nextCarry;
    logic                 nextOverflow;

    // A < B when the difference is negative, unless the subtraction overflowed
    assign sltWord = {{(dataWidth-1){1'b0}}, sum[dataWidth-1] ^ arithOverflow};

    always_comb begin
        case (resultSel)
            selArith: nextResult = sum;
            selXor:   nextResult = xorResult;
            selSlt:   nextResult = sltWord;
            selNand:  nextResult = nandResult;
            selNor:   nextResult = norResult;
            default:  nextResult = '0;
        endcase
    end

    // Flags only mean something for ADD and SUB
    assign isArith      = (resultSel == selArith);
    assign nextCarry    = isArith & arithCarry;
    assign nextOverflow = isArith & arithOverflow;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result   <= '0;
            carryOut <= 1'b0;
            overflow <= 1'b0;
        end else begin
            result   <= nextResult;
            carryOut <= nextCarry;
            overflow <= nextOverflow;
        end
    end

    assign zero = ~|result;

    // SLT and the logic ops never leak the adder flags
    assert property (@(posedge clk) disable iff (!arstN)
        (resultSel != selArith) |=> (!carryOut && !overflow))
        else $error("Arithmetic flag set after a non-arithmetic select");

    // zero tracks the word selected one cycle earlier
    assert property (@(posedge clk) disable iff (!arstN)
        1'b1 |=> (zero == ($past(nextResult) == '0)))
        else $error("zero flag does not match the captured result");

endmodule

/* logicUnit.sv */
// Bitwise XOR, NAND/AND and NOR/OR unit with a shared output inversion
`timescale 1ns/1ps

module logicUnit #(
    parameter int dataWidth = 32
) (
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  logic                 invertOut,
    output logic [dataWidth-1:0] xorResult,
    output logic [dataWidth-1:0] nandResult,
    output logic [dataWidth-1:0] norResult
);

    logic [dataWidth-1:0] invMask;
    logic [dataWidth-1:0] nandRaw;
    logic [dataWidth-1:0] norRaw;

    assign invMask = {dataWidth{invertOut}};

    assign nandRaw = ~(a & b);
    assign norRaw  = ~(a | b);

    assign xorResult = a ^ b;

    // Inverting NAND and NOR gives AND and OR
    assign nandResult = nandRaw ^ invMask;
    assign norResult  = norRaw ^ invMask;

endmodule

/* adderSubtractor.sv */
// Ripple-carry adder with optional operand-B inversion for subtraction
`timescale 1ns/1ps

module adderSubtractor #(
    parameter int dataWidth = 32
) (
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  logic                 invertB,
    input  logic                 carryIn,
    output logic [dataWidth-1:0] sum,
    output logic                 carryOut,
    output logic                 overflow
);

    // carry[i] is the carry into bit i
    logic [dataWidth:0]   carry;
    logic [dataWidth-1:0] bIn;
    logic [dataWidth-1:0] halfSum;

    assign bIn      = b ^ {dataWidth{invertB}};
    assign carry[0] = carryIn;

    genvar i;
    generate
        for (i = 0; i < dataWidth; i = i + 1) begin : gRipple
            assign halfSum[i]   = a[i] ^ bIn[i];
            assign sum[i]       = halfSum[i] ^ carry[i];
            // Generate or propagate
            assign carry[i + 1] = (a[i] & bIn[i]) | (halfSum[i] & carry[i]);
        end
    endgenerate

    assign carryOut = carry[dataWidth];

    // Signed overflow when the carry into the sign bit differs from the carry out
    assign overflow = carry[dataWidth-1] ^ carry[dataWidth];

endmodule

/* aluControl.sv */
// ALU command decoder producing the result select and the adder and logic controls
`timescale 1ns/1ps

module aluControl (
    input  aluPkg::aluCmd_t    command,
    output aluPkg::resultSel_t resultSel,
    output logic               invertB,
    output logic               invertOut,
    output logic               carryIn
);

    import aluPkg::*;

    always_comb begin
        resultSel = selArith;
        invertB   = 1'b0;
        invertOut = 1'b0;
        carryIn   = 1'b0;
        case (command)
            cmdAdd: begin
                resultSel = selArith;
            end
            cmdSub: begin
                resultSel = selArith;
                invertB   = 1'b1;
                carryIn   = 1'b1;
            end
            // SLT runs a subtraction and keeps only its sign
            cmdSlt: begin
                resultSel = selSlt;
                invertB   = 1'b1;
                carryIn   = 1'b1;
            end
            cmdXor: begin
                resultSel = selXor;
            end
            cmdNand: begin
                resultSel = selNand;
            end
            cmdAnd: begin
                resultSel = selNand;
                invertOut = 1'b1;
            end
            cmdNor: begin
                resultSel = selNor;
            end
            cmdOr: begin
                resultSel = selNor;
                invertOut = 1'b1;
            end
            default: begin
                resultSel = selArith;
            end
        endcase
    end

endmodule

/* aluPkg.sv */
// ALU package with command codes, result-select codes and the default operand width
package aluPkg;

    // Operand width used by the top level unless overridden
    localparam int defaultDataWidth = 32;

    // Operation code driven into the ALU
    typedef logic [2:0] aluCmd_t;

    localparam aluCmd_t cmdAdd  = 3'd0;
    localparam aluCmd_t cmdSub  = 3'd1;
    localparam aluCmd_t cmdXor  = 3'd2;
    localparam aluCmd_t cmdSlt  = 3'd3;
    localparam aluCmd_t cmdAnd  = 3'd4;
    localparam aluCmd_t cmdNand = 3'd5;
    localparam aluCmd_t cmdNor  = 3'd6;
    localparam aluCmd_t cmdOr   = 3'd7;

    // Which datapath unit reaches the result
    typedef logic [2:0] resultSel_t;

    // Adder output, used by ADD and SUB
    localparam resultSel_t selArith = 3'd0;
    localparam resultSel_t selXor   = 3'd1;
    localparam resultSel_t selSlt   = 3'd2;
    // NAND unit, also gives AND with the output inverted
    localparam resultSel_t selNand  = 3'd3;
    // NOR unit, also gives OR with the output inverted
    localparam resultSel_t selNor   = 3'd4;

endpackage
